//--- mem_subsys_defs.svh
// widths and bank sizing for the memory subsystem; MS_MEM_WORDS must equal 2**MS_WORD_IDX_W
`ifndef MEM_SUBSYS_DEFS_SVH
`define MEM_SUBSYS_DEFS_SVH

// bus geometry, AXI4-Lite with 32 bit address and data
`define MS_ADDR_W         32
`define MS_DATA_W         32
`define MS_STRB_W         4             // one strobe per byte lane

// bank sizing
`define MS_MEM_WORDS      1024          // words per bank
`define MS_WORD_IDX_W     10            // log2 of the bank depth

// debug address regions, decoded from addr[23:20]
`define MS_REGION_INSTR   4'd0
`define MS_REGION_DATA    4'd1

// read value for a debug access outside both banks
`define MS_UNMAPPED_RDATA 32'hDEADBEEF

`endif

//--- mem_subsys_pkg.sv
// shared bus, memory and debug types; field widths follow the macros in mem_subsys_defs.svh
`include "mem_subsys_defs.svh"

package mem_subsys_pkg;

  // master driven AXI4-Lite fields
  typedef struct packed {
    logic [`MS_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic [`MS_DATA_W-1:0] wdata;
    logic [`MS_STRB_W-1:0] wstrb;
    logic                  wvalid;
    logic                  bready;
    logic [`MS_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  rready;
  } axil_req_t;

  // slave driven AXI4-Lite fields
  typedef struct packed {
    logic                  awready;
    logic                  wready;
    logic [1:0]            bresp;     // 0 okay, 2 slverr
    logic                  bvalid;
    logic                  arready;
    logic [`MS_DATA_W-1:0] rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
  } axil_rsp_t;

  // one RAM port access, single cycle
  typedef struct packed {
    logic                      en;
    logic                      we;
    logic [`MS_STRB_W-1:0]     be;        // byte write mask
    logic [`MS_WORD_IDX_W-1:0] word_idx;
    logic [`MS_DATA_W-1:0]     wdata;
  } mem_req_t;

  // debug address, seen as a raw word or as region and word index
  typedef union packed {
    logic [`MS_ADDR_W-1:0] raw;
    struct packed {
      logic [7:0]                unused_hi;
      logic [3:0]                region;    // addr[23:20]
      logic [7:0]                unused_mid;
      logic [`MS_WORD_IDX_W-1:0] word_idx;  // addr[11:2]
      logic [1:0]                byte_off;
    } fields;
  } dbg_addr_u;

  typedef struct packed {
    logic                  req;
    logic                  we;
    dbg_addr_u             addr;
    logic [`MS_DATA_W-1:0] wdata;
  } dbg_req_t;

  typedef struct packed {
    logic                  rvalid;     // one cycle after each request
    logic [`MS_DATA_W-1:0] rdata;
  } dbg_rsp_t;

endpackage

//--- axil_mem_bridge.sv
// AXI4-Lite slave to RAM port; one transaction at a time, write wins over read, out of range is SLVERR
`timescale 1ns/1ps
`include "mem_subsys_defs.svh"

module axil_mem_bridge
  import mem_subsys_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  axil_req_t             axi_req_i,
  output axil_rsp_t             axi_rsp_o,
  output mem_req_t              mem_req_o,
  input  logic [`MS_DATA_W-1:0] mem_rdata_i
);

  localparam logic [1:0] RespOkay   = 2'b00;
  localparam logic [1:0] RespSlverr = 2'b10;

  typedef enum logic [1:0] {
    ST_IDLE,                              // waiting for aw+w or ar
    ST_WRESP,                             // bvalid up, waiting for bready
    ST_RWAIT,                             // RAM read in flight
    ST_RRESP                              // rvalid up, waiting for rready
  } state_e;

  state_e                state_q, state_d;
  logic                  wr_go;           // write accepted this cycle
  logic                  rd_go;           // read accepted this cycle
  logic [`MS_ADDR_W-1:0] acc_addr;        // address of the accepted access
  logic                  in_range;
  logic [1:0]            resp_q;          // shared by b and r channels
  logic [`MS_DATA_W-1:0] rdata_q;         // holds rdata under back-pressure

  // accept only from idle, write needs both aw and w
  assign wr_go    = (state_q == ST_IDLE) && axi_req_i.awvalid && axi_req_i.wvalid;
  assign rd_go    = (state_q == ST_IDLE) && !wr_go && axi_req_i.arvalid;
  assign acc_addr = wr_go ? axi_req_i.awaddr : axi_req_i.araddr;
  assign in_range = (acc_addr >> 2) < `MS_ADDR_W'(`MS_MEM_WORDS);

  // RAM request, suppressed for out of range addresses
  always_comb begin
    mem_req_o          = '0;
    mem_req_o.en       = (wr_go || rd_go) && in_range;
    mem_req_o.we       = wr_go;
    mem_req_o.be       = wr_go ? axi_req_i.wstrb : '0;
    mem_req_o.word_idx = acc_addr[`MS_WORD_IDX_W+1:2];
    mem_req_o.wdata    = axi_req_i.wdata;
  end

  // response channels come straight from state and holding regs
  always_comb begin
    axi_rsp_o         = '0;
    axi_rsp_o.awready = wr_go;             // aw and w taken together
    axi_rsp_o.wready  = wr_go;
    axi_rsp_o.arready = rd_go;
    axi_rsp_o.bvalid  = (state_q == ST_WRESP);
    axi_rsp_o.bresp   = resp_q;
    axi_rsp_o.rvalid  = (state_q == ST_RRESP);
    axi_rsp_o.rdata   = rdata_q;
    axi_rsp_o.rresp   = resp_q;
  end

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_IDLE: begin
        if (wr_go) begin
          state_d = ST_WRESP;             // RAM written at this edge
        end else if (rd_go) begin
          state_d = ST_RWAIT;
        end
      end
      ST_WRESP: begin
        if (axi_req_i.bready) begin
          state_d = ST_IDLE;
        end
      end
      ST_RWAIT: begin
        state_d = ST_RRESP;               // RAM output valid now
      end
      ST_RRESP: begin
        if (axi_req_i.rready) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // response payload, captured once per transaction
  always_ff @(posedge clk_i) begin
    if (wr_go || rd_go) begin
      resp_q <= in_range ? RespOkay : RespSlverr;
    end
    if (state_q == ST_RWAIT) begin
      rdata_q <= (resp_q == RespOkay) ? mem_rdata_i : '0;  // zero on slverr
    end
  end

endmodule

//--- dual_port_ram.sv
// true dual-port RAM, single clock, read-old-data; on a same-word write collision port B wins
`timescale 1ns/1ps
`include "mem_subsys_defs.svh"

module dual_port_ram
  import mem_subsys_pkg::*;
(
  input  logic                  clk_i,
  input  mem_req_t              a_req_i,   // bus side
  output logic [`MS_DATA_W-1:0] a_rdata_o,
  input  mem_req_t              b_req_i,   // debug side
  output logic [`MS_DATA_W-1:0] b_rdata_o
);

  logic [`MS_DATA_W-1:0] mem_q [`MS_MEM_WORDS];

  // merge the enabled byte lanes of new into old
  function automatic logic [`MS_DATA_W-1:0] byte_merge(
    input logic [`MS_DATA_W-1:0] old_word,
    input logic [`MS_DATA_W-1:0] new_word,
    input logic [`MS_STRB_W-1:0] be
  );
    logic [`MS_DATA_W-1:0] merged;
    merged = old_word;
    for (int b = 0; b < `MS_STRB_W; b++) begin
      if (be[b]) begin
        merged[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return merged;
  endfunction

  always_ff @(posedge clk_i) begin
    // port A
    if (a_req_i.en) begin
      if (a_req_i.we) begin
        mem_q[a_req_i.word_idx] <= byte_merge(mem_q[a_req_i.word_idx], a_req_i.wdata,
                                              a_req_i.be);
      end
      a_rdata_o <= mem_q[a_req_i.word_idx];  // registered read
    end
    // port B last, so its write lands over port A's
    if (b_req_i.en) begin
      if (b_req_i.we) begin
        mem_q[b_req_i.word_idx] <= byte_merge(mem_q[b_req_i.word_idx], b_req_i.wdata,
                                              b_req_i.be);
      end
      b_rdata_o <= mem_q[b_req_i.word_idx];
    end
  end

endmodule

//--- debug_port_mux.sv
// debug access to the two banks by addr[23:20]; no back-pressure, writes to other regions are dropped
`timescale 1ns/1ps
`include "mem_subsys_defs.svh"

module debug_port_mux
  import mem_subsys_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  dbg_req_t              dbg_req_i,
  output dbg_rsp_t              dbg_rsp_o,
  output mem_req_t              instr_req_o,
  output mem_req_t              data_req_o,
  input  logic [`MS_DATA_W-1:0] instr_rdata_i,
  input  logic [`MS_DATA_W-1:0] data_rdata_i
);

  dbg_addr_u  dbg_addr;
  logic [3:0] region;
  logic       hit_instr, hit_data;
  mem_req_t   bank_req;                    // fields common to both banks
  logic [3:0] region_q;                    // region of last request
  logic       rvalid_q;

  assign dbg_addr  = dbg_req_i.addr;
  assign region    = dbg_addr.fields.region;
  assign hit_instr = dbg_req_i.req && (region == `MS_REGION_INSTR);
  assign hit_data  = dbg_req_i.req && (region == `MS_REGION_DATA);

  always_comb begin
    bank_req          = '0;
    bank_req.we       = dbg_req_i.we;
    bank_req.be       = '1;                // debug writes full words
    bank_req.word_idx = dbg_addr.fields.word_idx;
    bank_req.wdata    = dbg_req_i.wdata;
    instr_req_o       = bank_req;
    instr_req_o.en    = hit_instr;         // only the addressed bank
    data_req_o        = bank_req;
    data_req_o.en     = hit_data;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      region_q <= '0;
    end else begin
      rvalid_q <= dbg_req_i.req;           // every access answers next cycle
      region_q <= region;
    end
  end

  // pick the bank that was addressed a cycle ago
  always_comb begin
    dbg_rsp_o.rvalid = rvalid_q;
    case (region_q)
      `MS_REGION_INSTR: dbg_rsp_o.rdata = instr_rdata_i;
      `MS_REGION_DATA:  dbg_rsp_o.rdata = data_rdata_i;
      default:          dbg_rsp_o.rdata = `MS_UNMAPPED_RDATA;
    endcase
  end

endmodule

//--- mem_subsys_top.sv
// two AXI4-Lite memory banks plus a debug port, all on clk_i; one outstanding transaction per bus port
`timescale 1ns/1ps
`include "mem_subsys_defs.svh"

module mem_subsys_top
  import mem_subsys_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  axil_req_t instr_axi_req_i,   // instruction bank bus
  output axil_rsp_t instr_axi_rsp_o,
  input  axil_req_t data_axi_req_i,    // data bank bus
  output axil_rsp_t data_axi_rsp_o,
  input  dbg_req_t  dbg_req_i,
  output dbg_rsp_t  dbg_rsp_o
);

  // port A, bus side
  mem_req_t              instr_a_req, data_a_req;
  logic [`MS_DATA_W-1:0] instr_a_rdata, data_a_rdata;
  // port B, debug side
  mem_req_t              instr_b_req, data_b_req;
  logic [`MS_DATA_W-1:0] instr_b_rdata, data_b_rdata;

  axil_mem_bridge i_instr_bridge (
    .clk_i       ( clk_i           ),
    .rst_ni      ( rst_ni          ),
    .axi_req_i   ( instr_axi_req_i ),
    .axi_rsp_o   ( instr_axi_rsp_o ),
    .mem_req_o   ( instr_a_req     ),
    .mem_rdata_i ( instr_a_rdata   )
  );

  dual_port_ram i_instr_ram (
    .clk_i     ( clk_i         ),
    .a_req_i   ( instr_a_req   ),
    .a_rdata_o ( instr_a_rdata ),
    .b_req_i   ( instr_b_req   ),
    .b_rdata_o ( instr_b_rdata )
  );

  axil_mem_bridge i_data_bridge (
    .clk_i       ( clk_i          ),
    .rst_ni      ( rst_ni         ),
    .axi_req_i   ( data_axi_req_i ),
    .axi_rsp_o   ( data_axi_rsp_o ),
    .mem_req_o   ( data_a_req     ),
    .mem_rdata_i ( data_a_rdata   )
  );

  dual_port_ram i_data_ram (
    .clk_i     ( clk_i        ),
    .a_req_i   ( data_a_req   ),
    .a_rdata_o ( data_a_rdata ),
    .b_req_i   ( data_b_req   ),
    .b_rdata_o ( data_b_rdata )
  );

  // debug reaches both banks through port B
  debug_port_mux i_debug_mux (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .dbg_req_i     ( dbg_req_i     ),
    .dbg_rsp_o     ( dbg_rsp_o     ),
    .instr_req_o   ( instr_b_req   ),
    .data_req_o    ( data_b_req    ),
    .instr_rdata_i ( instr_b_rdata ),
    .data_rdata_i  ( data_b_rdata  )
  );

endmodule

//--- tb_clock_gen.sv
// free-running 40 ns clock; reset low from time zero for 16 rising edges, released on a falling edge
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int half_period_ns = 20;
  localparam int reset_cycles   = 16;

  initial begin
    clk_o = 1'b0;
    forever #(half_period_ns) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;                         // away from the rising edge
  end

endmodule

//--- mem_subsys_checker.sv
// handshake properties for both bus ports and the debug port; checked only while rst_ni is high
`timescale 1ns/1ps

module mem_subsys_checker
  import mem_subsys_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input axil_req_t instr_req_i,
  input axil_rsp_t instr_rsp_i,
  input axil_req_t data_req_i,
  input axil_rsp_t data_rsp_i,
  input dbg_req_t  dbg_req_i,
  input dbg_rsp_t  dbg_rsp_i
);

  // first cycle out of reset, no response may be pending
  assert property (@(posedge clk_i) $rose(rst_ni) |-> !instr_rsp_i.bvalid && !instr_rsp_i.rvalid
                   && !data_rsp_i.bvalid && !data_rsp_i.rvalid && !dbg_rsp_i.rvalid)
    else $error("valid output high right after reset");

  // write response held with stable bresp until bready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   instr_rsp_i.bvalid && !instr_req_i.bready
                   |=> instr_rsp_i.bvalid && $stable(instr_rsp_i.bresp))
    else $error("instr bvalid or bresp changed before bready");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   data_rsp_i.bvalid && !data_req_i.bready
                   |=> data_rsp_i.bvalid && $stable(data_rsp_i.bresp))
    else $error("data bvalid or bresp changed before bready");

  // read response held, rdata frozen, until rready
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   instr_rsp_i.rvalid && !instr_req_i.rready
                   |=> instr_rsp_i.rvalid && $stable(instr_rsp_i.rdata))
    else $error("instr rvalid or rdata changed before rready");
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   data_rsp_i.rvalid && !data_req_i.rready
                   |=> data_rsp_i.rvalid && $stable(data_rsp_i.rdata))
    else $error("data rvalid or rdata changed before rready");

  // debug answers every request exactly one cycle later, and nothing else
  assert property (@(posedge clk_i) disable iff (!rst_ni)
                   dbg_rsp_i.rvalid == $past(dbg_req_i.req))
    else $error("debug rvalid does not follow request by one cycle");

endmodule

bind mem_subsys_top mem_subsys_checker i_checker (
  .clk_i       ( clk_i           ),
  .rst_ni      ( rst_ni          ),
  .instr_req_i ( instr_axi_req_i ),
  .instr_rsp_i ( instr_axi_rsp_o ),
  .data_req_i  ( data_axi_req_i  ),
  .data_rsp_i  ( data_axi_rsp_o  ),
  .dbg_req_i   ( dbg_req_i       ),
  .dbg_rsp_i   ( dbg_rsp_o       )
);

//--- mem_subsys_tb.sv
// directed tests of both bus ports and the debug port; a RAM word is only read after a test wrote it
`timescale 1ns/1ps
`include "mem_subsys_defs.svh"

module mem_subsys_tb
  import mem_subsys_pkg::*;
();

  localparam int clk_period_ns      = 40;
  localparam int reset_cycles       = 16;
  localparam int num_tests          = 6;
  localparam int test_budget_cycles = 500;  // longest test needs about a quarter of this

  logic                  clk, rst_n;
  axil_req_t             bus_req [2];      // 0 instruction, 1 data
  axil_rsp_t             bus_rsp [2];
  dbg_req_t              dbg_req;
  dbg_rsp_t              dbg_rsp;
  logic [`MS_DATA_W-1:0] model [2][`MS_MEM_WORDS];  // expected bank contents
  integer                seed = 32'hdde0;

  tb_clock_gen i_clock_gen (.clk_o(clk), .rst_no(rst_n));

  mem_subsys_top dut (
    .clk_i           ( clk        ),
    .rst_ni          ( rst_n      ),
    .instr_axi_req_i ( bus_req[0] ),
    .instr_axi_rsp_o ( bus_rsp[0] ),
    .data_axi_req_i  ( bus_req[1] ),
    .data_axi_rsp_o  ( bus_rsp[1] ),
    .dbg_req_i       ( dbg_req    ),
    .dbg_rsp_o       ( dbg_rsp    )
  );

  function automatic logic [31:0] next_random();
    next_random = $random(seed);
  endfunction

  // beyond sets bit 12, one full bank past the word
  function automatic logic [31:0] word_addr(input logic [9:0] idx, input logic beyond);
    word_addr = {19'h0, beyond, idx, 2'b00};
  endfunction

  function automatic logic [31:0] strobe_merge(input logic [31:0] old_word, new_word,
                                               input logic [3:0] strb);
    logic [31:0] mask;
    mask         = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    strobe_merge = (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic check_eq(input string name, input logic [31:0] expected, actual);
    if (actual !== expected) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // all bus and debug tasks start and return on a falling edge
  task automatic axil_write(input bit port, input logic [31:0] addr, wdata,
                            input logic [3:0] strb, input int hold, output logic [1:0] resp);
    bus_req[port].awaddr  = addr;
    bus_req[port].awvalid = 1'b1;
    bus_req[port].wdata   = wdata;
    bus_req[port].wstrb   = strb;
    bus_req[port].wvalid  = 1'b1;
    bus_req[port].bready  = 1'b0;
    #(clk_period_ns / 4);                  // readies are combinational, look before the edge
    check_eq("awready on accept", 32'd1, 32'(bus_rsp[port].awready));
    check_eq("wready on accept", 32'd1, 32'(bus_rsp[port].wready));
    check_eq("arready during write accept", 32'd0, 32'(bus_rsp[port].arready));
    @(negedge clk);
    while (!bus_rsp[port].bvalid) @(negedge clk);  // accepted on the last rising edge
    bus_req[port].awvalid = 1'b0;
    bus_req[port].wvalid  = 1'b0;
    resp = bus_rsp[port].bresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_eq("bvalid held", 32'd1, 32'(bus_rsp[port].bvalid));
      check_eq("bresp held", 32'(resp), 32'(bus_rsp[port].bresp));
      check_eq("arready while bvalid", 32'd0, 32'(bus_rsp[port].arready));
    end
    bus_req[port].bready = 1'b1;
    @(negedge clk);
    check_eq("bvalid after handshake", 32'd0, 32'(bus_rsp[port].bvalid));
    bus_req[port].bready = 1'b0;
  endtask

  task automatic axil_read(input bit port, input logic [31:0] addr, input int hold,
                           output logic [31:0] rdata, output logic [1:0] resp);
    bus_req[port].araddr  = addr;
    bus_req[port].arvalid = 1'b1;
    bus_req[port].rready  = 1'b0;
    #(clk_period_ns / 4);
    check_eq("arready on accept", 32'd1, 32'(bus_rsp[port].arready));
    @(negedge clk);
    while (!bus_rsp[port].rvalid) @(negedge clk);
    bus_req[port].arvalid = 1'b0;
    rdata = bus_rsp[port].rdata;
    resp  = bus_rsp[port].rresp;
    for (int i = 0; i < hold; i++) begin
      @(negedge clk);
      check_eq("rvalid held", 32'd1, 32'(bus_rsp[port].rvalid));
      check_eq("rdata held", rdata, bus_rsp[port].rdata);
      check_eq("rresp held", 32'(resp), 32'(bus_rsp[port].rresp));
    end
    bus_req[port].rready = 1'b1;
    @(negedge clk);
    check_eq("rvalid after handshake", 32'd0, 32'(bus_rsp[port].rvalid));
    bus_req[port].rready = 1'b0;
  endtask

  task automatic dbg_access(input logic we, input logic [3:0] region, input logic [9:0] idx,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    dbg_req.req                  = 1'b1;
    dbg_req.we                   = we;
    dbg_req.addr.raw             = '0;
    dbg_req.addr.fields.region   = region;
    dbg_req.addr.fields.word_idx = idx;
    dbg_req.wdata                = wdata;
    @(negedge clk);
    check_eq("dbg rvalid", 32'd1, 32'(dbg_rsp.rvalid));  // one cycle after the request
    rdata       = dbg_rsp.rdata;
    dbg_req.req = 1'b0;
    @(negedge clk);
    check_eq("dbg rvalid one cycle only", 32'd0, 32'(dbg_rsp.rvalid));
  endtask

  task automatic test_byte_strobes();
    logic [31:0] rnd, wdata, rdata;
    logic [9:0]  idx;
    logic [3:0]  strb;
    logic [1:0]  resp;
    for (int n = 0; n < 4; n++) begin
      rnd   = next_random();
      idx   = rnd[9:0];
      wdata = next_random();
      axil_write(1'b0, word_addr(idx, 1'b0), wdata, 4'hf, 0, resp);  // known base word
      model[0][idx] = wdata;
      for (int k = 0; k < 3; k++) begin
        rnd   = next_random();
        strb  = (rnd[3:0] == 4'h0 || rnd[3:0] == 4'hf) ? 4'b0110 : rnd[3:0];
        wdata = next_random();
        axil_write(1'b0, word_addr(idx, 1'b0), wdata, strb, 0, resp);
        check_eq("bresp partial write", 32'd0, 32'(resp));
        model[0][idx] = strobe_merge(model[0][idx], wdata, strb);
      end
      axil_read(1'b0, word_addr(idx, 1'b0), 0, rdata, resp);
      check_eq("rdata merged", model[0][idx], rdata);
      check_eq("rresp merged", 32'd0, 32'(resp));
    end
  endtask

  task automatic test_independent_banks();
    logic [31:0] rnd, instr_word, data_word, rdata;
    logic [9:0]  idx;
    logic [1:0]  resp;
    for (int n = 0; n < 4; n++) begin
      rnd        = next_random();
      idx        = rnd[9:0];
      instr_word = next_random();
      data_word  = next_random();
      if (data_word == instr_word) data_word = ~instr_word;
      axil_write(1'b0, word_addr(idx, 1'b0), instr_word, 4'hf, 0, resp);
      model[0][idx] = instr_word;
      axil_write(1'b1, word_addr(idx, 1'b0), data_word, 4'hf, 0, resp);
      model[1][idx] = data_word;
      for (int p = 0; p < 2; p++) begin
        axil_read(p[0], word_addr(idx, 1'b0), 0, rdata, resp);
        check_eq("rdata own bank", model[p[0]][idx], rdata);
      end
    end
  endtask

  task automatic test_debug_reads();
    logic [31:0] rnd, rdata;
    logic [9:0]  idx;
    logic [1:0]  resp;
    for (int n = 0; n < 8; n++) begin
      rnd = next_random();
      idx = rnd[9:0];
      rnd = next_random();
      axil_write(n[0], word_addr(idx, 1'b0), rnd, 4'hf, 0, resp);
      model[n[0]][idx] = rnd;
      dbg_access(1'b0, n[0] ? `MS_REGION_DATA : `MS_REGION_INSTR, idx, 32'h0, rdata);
      check_eq("dbg rdata of bus write", model[n[0]][idx], rdata);
    end
  endtask

  task automatic test_debug_writes();
    logic [31:0] rnd, rdata;
    logic [9:0]  idx;
    logic [1:0]  resp;
    for (int n = 0; n < 4; n++) begin
      rnd = next_random();
      idx = rnd[9:0];
      rnd = next_random();
      dbg_access(1'b1, n[0] ? `MS_REGION_DATA : `MS_REGION_INSTR, idx, rnd, rdata);
      model[n[0]][idx] = rnd;
      axil_read(n[0], word_addr(idx, 1'b0), 0, rdata, resp);
      check_eq("bus rdata of debug write", model[n[0]][idx], rdata);
    end
    rnd = next_random();                    // unmapped region 2, same word in both banks
    idx = rnd[9:0];
    for (int p = 0; p < 2; p++) begin
      rnd = next_random();
      axil_write(p[0], word_addr(idx, 1'b0), rnd, 4'hf, 0, resp);
      model[p[0]][idx] = rnd;
    end
    dbg_access(1'b1, 4'h2, idx, next_random(), rdata);
    dbg_access(1'b0, 4'h2, idx, 32'h0, rdata);
    check_eq("dbg rdata unmapped", `MS_UNMAPPED_RDATA, rdata);
    for (int p = 0; p < 2; p++) begin
      axil_read(p[0], word_addr(idx, 1'b0), 0, rdata, resp);
      check_eq("bank after unmapped write", model[p[0]][idx], rdata);
    end
  endtask

  task automatic test_out_of_range();
    logic [31:0] rnd, rdata;
    logic [9:0]  idx;
    logic [1:0]  resp;
    for (int n = 0; n < 4; n++) begin
      rnd = next_random();
      idx = rnd[9:0];
      rnd = next_random();
      axil_write(n[0], word_addr(idx, 1'b0), rnd, 4'hf, 0, resp);
      model[n[0]][idx] = rnd;
      axil_write(n[0], word_addr(idx, 1'b1), ~rnd, 4'hf, 0, resp);  // low bits alias idx
      check_eq("bresp out of range", 32'd2, 32'(resp));
      axil_read(n[0], word_addr(idx, 1'b1), 0, rdata, resp);
      check_eq("rresp out of range", 32'd2, 32'(resp));
      check_eq("rdata out of range", 32'd0, rdata);
      axil_read(n[0], word_addr(idx, 1'b0), 0, rdata, resp);
      check_eq("rdata after out of range write", model[n[0]][idx], rdata);
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] rnd, addr, wdata, rdata;
    logic [1:0]  resp;
    int          hold_w, hold_r;
    for (int n = 0; n < 4; n++) begin
      rnd    = next_random();
      addr   = word_addr(rnd[9:0], 1'b0);
      hold_w = 1 + int'(rnd[14:12]);
      hold_r = 1 + int'(rnd[18:16]);
      wdata  = next_random();
      bus_req[n[0]].araddr  = addr;         // read pending behind the write
      bus_req[n[0]].arvalid = 1'b1;
      axil_write(n[0], addr, wdata, 4'hf, hold_w, resp);
      model[n[0]][rnd[9:0]] = wdata;
      axil_read(n[0], addr, hold_r, rdata, resp);
      check_eq("rdata after back-pressure", model[n[0]][rnd[9:0]], rdata);
    end
  endtask

  // watchdog sized from the test count
  initial begin
    #((reset_cycles + num_tests * test_budget_cycles) * clk_period_ns);
    $display("Timeout: the tests hung and did not finish within the cycle budget");
    $display("RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  initial begin
    bus_req[0] = '0;
    bus_req[1] = '0;
    dbg_req    = '0;
    @(posedge rst_n);
    @(negedge clk);
    check_eq("valid after reset", 32'd0, 32'({bus_rsp[0].bvalid, bus_rsp[0].rvalid,
             bus_rsp[1].bvalid, bus_rsp[1].rvalid, dbg_rsp.rvalid}));
    test_byte_strobes();
    test_independent_banks();
    test_debug_reads();
    test_debug_writes();
    test_out_of_range();
    test_back_pressure();
    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- files.f
+incdir+.
mem_subsys_pkg.sv
axil_mem_bridge.sv
dual_port_ram.sv
debug_port_mux.sv
mem_subsys_top.sv
tb_clock_gen.sv
mem_subsys_checker.sv
mem_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator and run; exit status 0 only when the testbench reports a pass
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f files.f --top-module mem_subsys_tb -o mem_subsys_sim
sim_out=$(./obj_dir/mem_subsys_sim 2>&1 || true)
printf '%s\n' "$sim_out"
if printf '%s\n' "$sim_out" | grep -q "RESULT: PASS"; then
  exit 0
fi
exit 1
